// ==== Makefile ====
# Verilator build and run of the polynomial unit testbench.
VERILATOR ?= verilator
TOP       ?= tb_poly_unit
FILELIST  ?= poly_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/100ps -j 0
PASS_MSG  ?= Done: no errors
SOURCES   := $(wildcard src/*.sv tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== poly_unit.f ====
+incdir+tests
src/poly_pkg.sv
src/token_fifo.sv
src/cmd_decode.sv
src/poly_execute.sv
src/result_stage.sv
src/poly_unit_top.sv
tests/tb_poly_unit.sv

// ==== src/cmd_decode.sv ====
// Sender must respect its IN_DEPTH credits, and an over-degree STP still consumes all of its coefficient tokens.
`timescale 1ns/100ps
module cmd_decode
   import poly_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  word_t    in_token,
   output logic     in_credit,
   output logic     op_valid,
   output exec_op_t op,
   input  logic     op_ready
);
   typedef enum logic [1:0] {P_CMD, P_COEF, P_X} parse_state_t;

   parse_state_t state;
   word_t        head;                             // Buffer head token.
   logic         buf_empty;
   logic         pop;
   opcode_t      head_opc;
   slot_t        cur_slot;                         // Slot of current STP or EVP.
   degree_t      cur_degree;                       // Degree of current STP.
   degree_t      coef_cnt;                         // Coefficients taken so far.
   logic         last_coef;
   logic         over_degree;

   // ############################################################
   // Input buffer and credit return
   // ############################################################
   token_fifo #(
      .DEPTH  (IN_DEPTH),
      .item_t (word_t)
   ) in_buf (
      .clk       (clk),
      .rst       (rst),
      .push      (in_valid),
      .push_item (in_token),
      .pop       (pop),
      .pop_item  (head),
      .empty     (buf_empty),
      .full      ()                                // Credits keep it from overflowing.
   );

   assign pop       = !buf_empty && (op_ready || !op_valid);   // Header-only tokens pop freely.
   assign in_credit = pop;                         // One credit per token taken.

   // ############################################################
   // Parser
   // ############################################################
   assign head_opc    = opcode_t'(head[OPC_MSB:OPC_LSB]);
   assign last_coef   = (coef_cnt == cur_degree);
   assign over_degree = (cur_degree > degree_t'(MAX_DEGREE));

   always_comb
   begin
      op_valid  = 1'b0;
      op.kind   = K_BADOP;
      op.slot   = cur_slot;
      op.degree = cur_degree;
      op.term   = term_t'(coef_cnt);
      op.word   = head;
      case (state)
         P_CMD:
         begin
            op.slot   = head[SLOT_MSB:SLOT_LSB];
            op.degree = head[DEG_MSB:DEG_LSB];
            op.term   = '0;
            op.kind   = (head_opc == RST) ? K_CLEAR : K_BADOP;
            op_valid  = !buf_empty && (head_opc == RST || head_opc == RSV);   // STP/EVP emit nothing yet.
         end
         P_COEF:
         begin
            op.kind  = K_COEF;
            if (over_degree)
               op.term = last_coef ? term_t'(MAX_DEGREE) : '0;   // Top index flags the last one.
            op_valid = !buf_empty;
         end
         P_X:
         begin
            op.kind  = K_EVAL;                     // Word carries x.
            op_valid = !buf_empty;
         end
         default:
            op_valid = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state    <= P_CMD;
         coef_cnt <= '0;
      end
      else if (pop)
      begin
         case (state)
            P_CMD:
            begin
               coef_cnt <= '0;
               if (head_opc == STP)
                  state <= P_COEF;
               else if (head_opc == EVP)
                  state <= P_X;
            end
            P_COEF:
            begin
               if (last_coef)
               begin
                  state    <= P_CMD;               // Degree+1 tokens consumed.
                  coef_cnt <= '0;
               end
               else
                  coef_cnt <= coef_cnt + 1'b1;
            end
            P_X:
               state <= P_CMD;
            default:
               state <= P_CMD;
         endcase
      end
   end

   // Command fields held for the argument tokens.
   always_ff @(posedge clk)
   begin
      if (pop && state == P_CMD)
      begin
         cur_slot   <= head[SLOT_MSB:SLOT_LSB];
         cur_degree <= head[DEG_MSB:DEG_LSB];
      end
   end

endmodule

// ==== src/poly_execute.sv ====
// One operation at a time; EVP takes degree+1 cycles with op_ready low and arithmetic wraps modulo 2^32.
`timescale 1ns/100ps
module poly_execute
   import poly_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     op_valid,
   input  exec_op_t op,
   output logic     op_ready,
   output logic     rv_valid,
   output result_t  rv,
   input  logic     rv_ready
);
   typedef enum logic [1:0] {X_IDLE, X_EVAL, X_OUT} exec_state_t;

   exec_state_t          state;
   word_t                coef_mem [NUM_SLOTS][MAX_DEGREE+1];   // Coefficient store.
   term_t                slot_deg [NUM_SLOTS];                 // Stored degree per slot.
   logic [NUM_SLOTS-1:0] slot_valid;                           // Slot holds a polynomial.
   slot_t                eval_slot;
   term_t                eval_term;                            // Horner index, counts down.
   word_t                x_reg;
   acc_t                 acc;
   acc_t                 horner_next;
   result_t              res_reg;                              // Pending result.
   logic                 take;
   logic                 legal_deg;
   logic                 is_last;

   assign op_ready = (state == X_IDLE);
   assign rv_valid = (state == X_OUT);
   assign rv       = res_reg;
   assign take     = op_valid && op_ready;

   assign legal_deg = (op.degree <= degree_t'(MAX_DEGREE));
   assign is_last   = legal_deg ? (op.term == term_t'(op.degree))
                                : (op.term == term_t'(MAX_DEGREE));   // Decoder marks over-degree end.

   // Multiply by x, then add the next lower coefficient.
   assign horner_next = acc * acc_t'(x_reg) + acc_t'(coef_mem[eval_slot][eval_term]);

   // ############################################################
   // Control FSM and slot-valid table
   // ############################################################
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state      <= X_IDLE;
         slot_valid <= '0;
      end
      else
      begin
         case (state)
            X_IDLE:
            begin
               if (take)
               begin
                  case (op.kind)
                     K_COEF:
                     begin
                        if (is_last)
                        begin
                           state <= X_OUT;                   // STP reports degree.
                           if (legal_deg)
                              slot_valid[op.slot] <= 1'b1;
                        end
                     end
                     K_EVAL:
                        state <= slot_valid[op.slot] ? X_EVAL : X_OUT;
                     K_CLEAR:
                        slot_valid <= '0;                    // No result for RST.
                     default:
                        state <= X_OUT;                      // Bad opcode.
                  endcase
               end
            end
            X_EVAL:
            begin
               if (eval_term == '0)
                  state <= X_OUT;                            // Constant term added.
            end
            X_OUT:
            begin
               if (rv_ready)
                  state <= X_IDLE;                           // Stalls while queue full.
            end
            default:
               state <= X_IDLE;
         endcase
      end
   end

   // ############################################################
   // Memory, Horner datapath and result register
   // ############################################################
   always_ff @(posedge clk)
   begin
      if (take && op.kind == K_COEF)
      begin
         if (legal_deg)
            coef_mem[op.slot][op.term] <= op.word;           // Over-degree words dropped.
         if (is_last && legal_deg)
            slot_deg[op.slot] <= term_t'(op.degree);
         res_reg.value  <= acc_t'(op.degree);
         res_reg.status <= legal_deg ? ST_OK : ST_DEGREE;
      end
      else if (take && op.kind == K_EVAL)
      begin
         eval_slot      <= op.slot;
         eval_term      <= slot_deg[op.slot];                 // Start at top term.
         x_reg          <= op.word;
         acc            <= '0;
         res_reg.value  <= '0;                                // Kept only if slot undefined.
         res_reg.status <= ST_UNDEF;
      end
      else if (take && op.kind == K_BADOP)
      begin
         res_reg.value  <= '0;
         res_reg.status <= ST_BADOP;
      end
      else if (state == X_EVAL)
      begin
         acc       <= horner_next;
         eval_term <= eval_term - 1'b1;
         if (eval_term == '0)
         begin
            res_reg.value  <= horner_next;                    // Final sum.
            res_reg.status <= ST_OK;
         end
      end
   end

endmodule

// ==== src/poly_pkg.sv ====
// Field sizes assume NUM_SLOTS and MAX_DEGREE+1 are powers of two so slot and term indices fill their fields.
package poly_pkg;

   // ############################################################
   // Sizes
   // ############################################################
   localparam int WORD_W     = 16;   // Token and coefficient width.
   localparam int ACC_W      = 32;   // Result width.
   localparam int NUM_SLOTS  = 8;    // Polynomial slots.
   localparam int MAX_DEGREE = 7;    // Highest storable degree.
   localparam int IN_DEPTH   = 4;    // Input buffer, also sender credits.
   localparam int OUT_DEPTH  = 2;    // Result queue depth.

   // Command token bit positions.
   localparam int OPC_MSB  = 15;
   localparam int OPC_LSB  = 14;
   localparam int SLOT_MSB = 13;
   localparam int SLOT_LSB = 11;
   localparam int DEG_MSB  = 4;
   localparam int DEG_LSB  = 0;     // Bits 10..5 are ignored.

   // ############################################################
   // Types
   // ############################################################
   typedef logic [WORD_W-1:0]                word_t;     // Token or coefficient.
   typedef logic [ACC_W-1:0]                 acc_t;      // Horner accumulator.
   typedef logic [SLOT_MSB-SLOT_LSB:0]       slot_t;     // Slot number.
   typedef logic [DEG_MSB-DEG_LSB:0]         degree_t;   // Raw degree, may exceed MAX_DEGREE.
   typedef logic [$clog2(MAX_DEGREE+1)-1:0]  term_t;     // Coefficient index.

   typedef enum logic [1:0] {
      STP = 2'd0,                    // Store polynomial.
      EVP = 2'd1,                    // Evaluate polynomial.
      RST = 2'd2,                    // Clear all slots.
      RSV = 2'd3                     // Reserved.
   } opcode_t;

   typedef enum logic [1:0] {
      ST_OK     = 2'd0,
      ST_UNDEF  = 2'd1,              // EVP on an empty slot.
      ST_DEGREE = 2'd2,              // STP above MAX_DEGREE.
      ST_BADOP  = 2'd3               // Reserved opcode seen.
   } status_t;

   typedef enum logic [1:0] {
      K_COEF,                        // One STP coefficient.
      K_EVAL,                        // EVP with its x.
      K_CLEAR,                       // RST.
      K_BADOP                        // Reserved opcode.
   } exec_kind_t;

   // Operation from decode to execute, 29 bits.
   typedef struct packed {
      exec_kind_t kind;
      slot_t      slot;
      degree_t    degree;
      term_t      term;
      word_t      word;              // Coefficient or x.
   } exec_op_t;

   // Result record, 34 bits.
   typedef struct packed {
      acc_t    value;
      status_t status;
   } result_t;

endpackage

// ==== src/poly_unit_top.sv ====
// Both external ports use credit flow control with IN_DEPTH and OUT_DEPTH initial credits.
`timescale 1ns/100ps
module poly_unit_top
   import poly_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    in_valid,
   input  word_t   in_token,
   output logic    in_credit,
   output logic    res_valid,
   output result_t res,
   input  logic    res_credit
);
   exec_op_t op;                                   // Decode to execute.
   logic     op_valid;
   logic     op_ready;
   result_t  rv;                                   // Execute to result queue.
   logic     rv_valid;
   logic     rv_ready;

   cmd_decode cmd_decode_inst (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_token  (in_token),
      .in_credit (in_credit),
      .op_valid  (op_valid),
      .op        (op),
      .op_ready  (op_ready)
   );

   poly_execute poly_execute_inst (
      .clk      (clk),
      .rst      (rst),
      .op_valid (op_valid),
      .op       (op),
      .op_ready (op_ready),
      .rv_valid (rv_valid),
      .rv       (rv),
      .rv_ready (rv_ready)
   );

   result_stage result_stage_inst (
      .clk        (clk),
      .rst        (rst),
      .rv_valid   (rv_valid),
      .rv         (rv),
      .rv_ready   (rv_ready),
      .res_valid  (res_valid),
      .res        (res),
      .res_credit (res_credit)
   );

endmodule

// ==== src/result_stage.sv ====
// Receiver starts with OUT_DEPTH free slots and must return exactly one credit per result taken.
`timescale 1ns/100ps
module result_stage
   import poly_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    rv_valid,
   input  result_t rv,
   output logic    rv_ready,
   output logic    res_valid,
   output result_t res,
   input  logic    res_credit
);
   typedef logic [$clog2(OUT_DEPTH+1)-1:0] credit_t;

   credit_t credit_cnt;                            // Free slots at receiver.
   logic    q_empty;
   logic    q_full;
   logic    send;

   // ############################################################
   // Result queue
   // ############################################################
   token_fifo #(
      .DEPTH  (OUT_DEPTH),
      .item_t (result_t)
   ) res_q (
      .clk       (clk),
      .rst       (rst),
      .push      (rv_valid),                       // Ignored while full.
      .push_item (rv),
      .pop       (send),
      .pop_item  (res),
      .empty     (q_empty),
      .full      (q_full)
   );

   assign rv_ready  = !q_full;                     // Full queue stalls execute.
   assign send      = !q_empty && (credit_cnt != '0);
   assign res_valid = send;                        // One result per cycle at most.

   // ############################################################
   // Output credit counter
   // ############################################################
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         credit_cnt <= credit_t'(OUT_DEPTH);
      else
      begin
         case ({send, res_credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;     // Send and return cancel.
         endcase
      end
   end

endmodule

// ==== src/token_fifo.sv ====
// Needs DEPTH of at least 2 and silently drops a push when full or a pop when empty.
`timescale 1ns/100ps
module token_fifo
#(
   parameter int  DEPTH  = 2,
   parameter type item_t = logic
)
(
   input  logic  clk,
   input  logic  rst,
   input  logic  push,
   input  item_t push_item,
   input  logic  pop,
   output item_t pop_item,
   output logic  empty,
   output logic  full
);
   typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
   typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

   item_t mem [DEPTH];                             // Storage, no reset.
   ptr_t  wr_ptr;
   ptr_t  rd_ptr;
   cnt_t  count;                                   // Occupancy.
   logic  do_push;
   logic  do_pop;

   assign do_push  = push && !full;                // Drop on overflow.
   assign do_pop   = pop && !empty;                // Drop on underflow.
   assign empty    = (count == '0);
   assign full     = (count == cnt_t'(DEPTH));
   assign pop_item = mem[rd_ptr];                  // Head shown without a pop.

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_item;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // Wrap.
         if (do_pop)
            rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                // Both or neither.
         endcase
      end
   end

endmodule

// ==== tests/tb_tasks.svh ====
// Included inside the testbench module whose signals, counters and queues these tasks use.
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

   // ############################################################
   // Reference model of the slot table
   // ############################################################
   word_t model_coef [NUM_SLOTS][MAX_DEGREE+1];
   int    model_deg [NUM_SLOTS];
   bit    model_valid [NUM_SLOTS];                 // All slots start undefined.

   function automatic acc_t horner_ref(input int slot, input word_t x);
      acc_t acc;
      acc = '0;
      for (int i = model_deg[slot]; i >= 0; i--)
         acc = acc * acc_t'(x) + acc_t'(model_coef[slot][i]);   // Wraps at 2^32.
      return acc;
   endfunction

   // Opcode 15:14, slot 13:11, degree 4:0.
   function automatic word_t cmd_token(input opcode_t opc, input int slot, input int degree);
      word_t t;
      t        = '0;
      t[15:14] = opc;
      t[13:11] = 3'(slot);
      t[4:0]   = 5'(degree);
      return t;
   endfunction

   function automatic int credits_left();
      return IN_DEPTH + credits_back - tokens_sent;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
      end
   endtask

   // ############################################################
   // Token driving and result collection
   // ############################################################
   task automatic send_token(input word_t token);
      int waited;
      waited = 0;
      while (credits_left() == 0 && waited < CREDIT_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (credits_left() == 0)
      begin
         $display("Timeout: sender waited %0d cycles for an input credit", waited);
         errors++;
         finish_run();
      end
      else
      begin
         tokens_sent++;                            // Spend one credit.
         in_valid = 1'b1;
         in_token = token;
         @(negedge clk);
         in_valid = 1'b0;
      end
   endtask

   task automatic expect_result(input string what);
      result_t got;
      result_t want;
      int      waited;
      waited = 0;
      while (seen.size() == taken && waited < RES_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (seen.size() == taken)
      begin
         $display("Timeout: no result arrived for %s", what);
         errors++;
         finish_run();
      end
      else if (exp_q.size() == 0)
      begin
         $display("A result arrived for %s although none was expected", what);
         errors++;
         taken++;
      end
      else
      begin
         got  = seen[taken];
         want = exp_q.pop_front();
         taken++;
         res_credit = 1'b1;                        // Return one output credit.
         check({"res.value (", what, ")"}, got.value, want.value);
         check({"res.status (", what, ")"}, 32'(got.status), 32'(want.status));
         @(negedge clk);
         res_credit = 1'b0;
      end
   endtask

   // The stall flag is sampled at the rising edge, so it is stable here.
   task automatic wait_for_stall();
      int waited;
      waited = 0;
      while (!stalled && waited < STALL_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!stalled)
      begin
         $display("The sender never ran out of credit while results were held back");
         errors++;
      end
   endtask

   // ############################################################
   // Commands, each records its expected result first
   // ############################################################
   task automatic store_poly(input int slot, input int degree);
      word_t   coefs [$];
      result_t want;
      for (int i = 0; i <= degree; i++)
         coefs.push_back(word_t'($random(seed)));
      want.value  = acc_t'(degree);
      want.status = ST_OK;
      if (degree > MAX_DEGREE)
         want.status = ST_DEGREE;                  // Slot keeps its old contents.
      else
      begin
         for (int i = 0; i <= degree; i++)
            model_coef[slot][i] = coefs[i];
         model_deg[slot]   = degree;
         model_valid[slot] = 1'b1;
      end
      exp_q.push_back(want);
      send_token(cmd_token(STP, slot, degree));
      foreach (coefs[i])
         send_token(coefs[i]);                     // Lowest term first.
   endtask

   task automatic eval_poly(input int slot, input word_t x);
      result_t want;
      want.value  = '0;
      want.status = ST_UNDEF;
      if (model_valid[slot])
      begin
         want.value  = horner_ref(slot, x);
         want.status = ST_OK;
      end
      exp_q.push_back(want);
      send_token(cmd_token(EVP, slot, 0));
      send_token(x);
   endtask

   task automatic clear_slots();
      foreach (model_valid[s])
         model_valid[s] = 1'b0;
      send_token(cmd_token(RST, 0, 0));            // No result expected.
   endtask

   task automatic send_reserved(input int slot);
      result_t want;
      want.value  = '0;
      want.status = ST_BADOP;
      exp_q.push_back(want);
      send_token(cmd_token(RSV, slot, 3));         // Degree bits set but no arguments follow.
   endtask

`endif

// ==== tests/tb_poly_unit.sv ====
// Directed test of poly_unit_top with bounded waits and a fixed random seed; needs fork/join timing support.
`timescale 1ns/100ps
module tb_poly_unit
   import poly_pkg::*;
();
   localparam int CLK_HALF       = 5;              // 10 ns period.
   localparam int CREDIT_TIMEOUT = 200;            // Cycles a sender may wait for a credit.
   localparam int RES_TIMEOUT    = 200;            // Cycles to wait for one result.
   localparam int STALL_TIMEOUT  = 300;

   logic    clk;
   logic    rst;
   logic    in_valid;
   word_t   in_token;
   logic    in_credit;
   logic    res_valid;
   result_t res;
   logic    res_credit;

   int      tokens_sent  = 0;                      // Tokens pushed by the sender.
   int      credits_back = 0;                      // in_credit pulses seen.
   int      taken        = 0;                      // Results claimed by the checker.
   int      errors       = 0;
   int      checks       = 0;
   integer  seed;
   bit      sender_done;
   bit      stalled;                               // No credit left and results held.
   result_t seen [$];                              // Every result off the output port.
   result_t exp_q [$];                             // Expected results, command order.

   poly_unit_top poly_unit_top_inst (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_token   (in_token),
      .in_credit  (in_credit),
      .res_valid  (res_valid),
      .res        (res),
      .res_credit (res_credit)
   );

`include "tb_tasks.svh"

   initial
   begin
      clk = 1'b0;
      forever
         #CLK_HALF clk = ~clk;
   end

   // Outputs settle after the rising edge, so they are sampled at the next one.
   always @(posedge clk)
   begin
      if (in_credit)
         credits_back++;                           // One credit per popped token.
      if (res_valid)
         seen.push_back(res);
      stalled = (credits_left() == 0) && (seen.size() - taken == OUT_DEPTH);
   end

   // ############################################################
   // Directed tests
   // ############################################################
   task automatic test_store_eval();
      store_poly(0, MAX_DEGREE);
      expect_result("stp full degree");
      for (int s = 1; s < 4; s++)
      begin
         store_poly(s, $unsigned($random(seed)) % (MAX_DEGREE + 1));
         expect_result("stp random degree");
      end
      for (int n = 0; n < 8; n++)
      begin
         eval_poly(n % 4, word_t'($random(seed)));
         expect_result("evp random x");
      end
      eval_poly(0, 16'hffff);                      // Largest x wraps hardest.
      expect_result("evp x ffff");
   endtask

   task automatic test_undefined_slot();
      eval_poly(6, 16'h1234);                      // Slot 6 never stored.
      expect_result("evp never stored");
   endtask

   task automatic test_over_degree();
      int start;
      start = credits_back;
      store_poly(5, 9);
      expect_result("stp degree 9");
      check("tokens taken", credits_back - start, 11);   // Command plus 10 words.
      eval_poly(1, word_t'($random(seed)));
      expect_result("evp after over-degree");
      eval_poly(5, 16'h0003);                      // Rejected STP left it empty.
      expect_result("evp rejected slot");
   endtask

   task automatic test_clear();
      clear_slots();
      eval_poly(0, 16'h0002);
      expect_result("evp after rst");
      store_poly(3, 1);
      expect_result("stp after rst");
      eval_poly(3, word_t'($random(seed)));
      expect_result("evp restored slot");
   endtask

   task automatic test_backpressure();
      word_t x;
      x = word_t'($random(seed));
      sender_done = 1'b0;
      fork
         begin
            store_poly(4, 7);
            eval_poly(4, x);
            store_poly(5, 7);
            eval_poly(5, x);
            store_poly(6, 7);
            store_poly(7, 7);                      // Sender runs dry in the sixth command.
            sender_done = 1'b1;
         end
         begin
            wait_for_stall();
            repeat (30) @(negedge clk);            // Longer than any evaluation.
            check("held results", seen.size() - taken, OUT_DEPTH);
            check("sender credits", credits_left(), 0);
            check("sender done", 32'(sender_done), 0);
            for (int n = 0; n < 6; n++)
               expect_result("held result");
         end
      join
   endtask

   task automatic test_reserved_op();
      send_reserved(3);
      expect_result("reserved opcode");
      store_poly(2, 2);
      expect_result("stp after reserved");
      eval_poly(2, word_t'($random(seed)));
      expect_result("evp after reserved");
   endtask

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   endtask

   initial
   begin
      seed       = 32'h158f47f5;
      rst        = 1'b0;                           // Held for two cycles.
      in_valid   = 1'b0;
      in_token   = '0;
      res_credit = 1'b0;
      repeat (2) @(negedge clk);
      rst = 1'b1;
      test_store_eval();
      test_undefined_slot();
      test_over_degree();
      test_clear();
      test_backpressure();
      test_reserved_op();
      check("unclaimed results", seen.size() - taken, 0);
      check("missing results", exp_q.size(), 0);
      finish_run();
   end

endmodule
